//--- src/baser_rx_pkg.sv
// Shared codes for a 64-bit 10GBASE-R receiver that only accepts frame starts in lane 0
package baser_rx_pkg;

    // Sync headers
    localparam logic [1:0] sync_data = 2'b10;
    localparam logic [1:0] sync_ctrl = 2'b01;

    // First byte of a control block
    localparam logic [7:0] bt_ctrl    = 8'h1e; // Idle or error characters
    localparam logic [7:0] bt_os_4    = 8'h2d;
    localparam logic [7:0] bt_os_04   = 8'h55;
    localparam logic [7:0] bt_os_0    = 8'h4b;
    localparam logic [7:0] bt_start_0 = 8'h78; // Start in lane 0, D1..D7 follow
    localparam logic [7:0] bt_term_0  = 8'h87;
    localparam logic [7:0] bt_term_1  = 8'h99;
    localparam logic [7:0] bt_term_2  = 8'haa;
    localparam logic [7:0] bt_term_3  = 8'hb4;
    localparam logic [7:0] bt_term_4  = 8'hcc;
    localparam logic [7:0] bt_term_5  = 8'hd2;
    localparam logic [7:0] bt_term_6  = 8'he1;
    localparam logic [7:0] bt_term_7  = 8'hff;

    // Low three bits of a terminate class hold its data byte count
    typedef enum logic [3:0] {
        blk_idle   = 4'd0,
        blk_error  = 4'd1,
        blk_start  = 4'd2,
        blk_data   = 4'd4,
        blk_term_0 = 4'd8,
        blk_term_1 = 4'd9,
        blk_term_2 = 4'd10,
        blk_term_3 = 4'd11,
        blk_term_4 = 4'd12,
        blk_term_5 = 4'd13,
        blk_term_6 = 4'd14,
        blk_term_7 = 4'd15
    } blk_type_t;

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_payload = 2'd1,
        st_last    = 2'd2  // Extra beat after a long terminate
    } frame_state_t;

    // Reflected CRC-32, preset to all ones, no final inversion
    localparam logic [31:0] crc_poly    = 32'hEDB88320;
    localparam logic [31:0] crc_residue = 32'hDEBB20E3; // Left over after a good FCS

    localparam int fcs_bytes = 4;

endpackage

//--- src/baser_block_decoder.sv
// Input must already be descrambled and block locked. Lane 4 starts are reported as bad blocks
`timescale 1ns/10ps

module baser_block_decoder import baser_rx_pkg::*; (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic [63:0] encoded_rx_data,
    input  logic [1:0]  encoded_rx_hdr,
    output blk_type_t   blk_type,
    output logic [63:0] blk_data,
    output logic        rx_bad_block
);

    blk_type_t   type_next;
    logic        bad_next;
    logic [3:0]  type_code;
    logic [2:0]  term_len;
    logic [63:0] term_mask;
    logic [63:0] data_next;

    // Classify header and block type
    always_comb begin
        type_next = blk_idle;
        bad_next  = 1'b0;
        if (encoded_rx_hdr == sync_data) begin
            type_next = baser_rx_pkg::blk_data;
        end else if (encoded_rx_hdr == sync_ctrl) begin
            case (encoded_rx_data[7:0])
                bt_ctrl:    type_next = blk_idle;
                bt_os_4:    type_next = blk_idle;   // Ordered sets are dropped
                bt_os_04:   type_next = blk_idle;
                bt_os_0:    type_next = blk_idle;
                bt_start_0: type_next = blk_start;
                bt_term_0:  type_next = blk_term_0;
                bt_term_1:  type_next = blk_term_1;
                bt_term_2:  type_next = blk_term_2;
                bt_term_3:  type_next = blk_term_3;
                bt_term_4:  type_next = blk_term_4;
                bt_term_5:  type_next = blk_term_5;
                bt_term_6:  type_next = blk_term_6;
                bt_term_7:  type_next = blk_term_7;
                default: begin
                    type_next = blk_error;
                    bad_next  = 1'b1;
                end
            endcase
        end else begin
            // 00 and 11 are never legal
            type_next = blk_error;
            bad_next  = 1'b1;
        end
    end

    assign type_code = type_next;
    assign term_len  = type_code[2:0];
    assign term_mask = ~({64{1'b1}} << {term_len, 3'b000}); // Keeps term_len bytes

    // Terminate data moves down one lane past the type byte
    always_comb begin
        if (type_code[3]) begin
            data_next = (encoded_rx_data >> 8) & term_mask;
        end else begin
            data_next = encoded_rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            blk_type     <= blk_idle;
            rx_bad_block <= 1'b0;
        end else begin
            blk_type     <= type_next;
            rx_bad_block <= bad_next;
        end
    end

    always_ff @(posedge clk) begin
        blk_data <= data_next;
    end

endmodule

//--- src/baser_fcs_checker.sv
// Byte-serial CRC-32 over up to 8 bytes per clock. Start block bytes are never folded in
`timescale 1ns/10ps

module baser_fcs_checker import baser_rx_pkg::*; (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic        crc_restart,
    input  blk_type_t   blk_type,
    input  logic [63:0] blk_data,
    output logic        fcs_match
);

    logic [31:0] crc_state;
    logic [31:0] crc_next;
    logic [3:0]  type_code;
    logic [3:0]  byte_count;

    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] din);
        logic [31:0] crc;
        crc = crc_in ^ {24'd0, din};
        for (int b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ crc_poly) : (crc >> 1);
        end
        return crc;
    endfunction

    assign type_code = blk_type;

    always_comb begin
        if (blk_type == baser_rx_pkg::blk_data) begin
            byte_count = 4'd8;
        end else if (type_code[3]) begin
            byte_count = {1'b0, type_code[2:0]}; // Terminate k
        end else begin
            byte_count = 4'd0;
        end
    end

    // Lane 0 goes through first
    always_comb begin
        crc_next = crc_state;
        for (int i = 0; i < 8; i++) begin
            if (i < byte_count) begin
                crc_next = crc_byte(crc_next, blk_data[8*i +: 8]);
            end
        end
    end

    assign fcs_match = (crc_next == crc_residue);

    always_ff @(posedge clk) begin
        if (reset_crc || crc_restart) begin
            crc_state <= '1;
        end else begin
            crc_state <= crc_next;
        end
    end

endmodule

//--- src/baser_frame_fsm.sv
// No back-pressure on the beat stream. A frame needs cfg_rx_enable high when its start reaches d1
`timescale 1ns/10ps

module baser_frame_fsm import baser_rx_pkg::*; (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic        cfg_rx_enable,
    input  blk_type_t   blk_type,
    input  logic [63:0] blk_data,
    input  logic        fcs_match,
    output logic        crc_restart,
    output logic [63:0] rx_tdata,
    output logic [7:0]  rx_tkeep,
    output logic        rx_tvalid,
    output logic        rx_tlast,
    output logic        rx_tuser,
    output logic        error_bad_frame,
    output logic        error_bad_fcs
);

    frame_state_t state;
    frame_state_t state_next;
    blk_type_t    type_d1;
    logic [63:0]  data_d1;
    logic [3:0]   code_d0;
    logic [3:0]   code_d1;
    logic         fcs_saved;
    logic         save_fcs;
    logic [3:0]   keep_bytes;
    logic         tvalid_next;
    logic         tlast_next;
    logic         tuser_next;
    logic         bad_frame_next;
    logic         bad_fcs_next;

    assign code_d0 = blk_type;
    assign code_d1 = type_d1;

    always_comb begin
        state_next     = st_idle;
        crc_restart    = 1'b1;
        save_fcs       = 1'b0;
        keep_bytes     = 4'd0;
        tvalid_next    = 1'b0;
        tlast_next     = 1'b0;
        tuser_next     = 1'b0;
        bad_frame_next = 1'b0;
        bad_fcs_next   = 1'b0;
        case (state)
            st_idle: begin
                if (type_d1 == blk_start && cfg_rx_enable) begin
                    crc_restart = 1'b0; // First data block is in d0 now
                    state_next  = st_payload;
                end
            end
            st_payload: begin
                tvalid_next = 1'b1;
                keep_bytes  = 4'd8;
                if (blk_type == baser_rx_pkg::blk_data) begin
                    crc_restart = 1'b0;
                    state_next  = st_payload;
                end else if (code_d0[3] && code_d0[2:0] <= 3'd4) begin
                    // Part of the FCS sits at the top of the d1 word
                    keep_bytes = 4'd8 - (4'(fcs_bytes) - {1'b0, code_d0[2:0]});
                    tlast_next = 1'b1;
                    if (!fcs_match) begin
                        tuser_next     = 1'b1;
                        bad_frame_next = 1'b1;
                        bad_fcs_next   = 1'b1;
                    end
                end else if (code_d0[3]) begin
                    save_fcs   = 1'b1; // Checked on the extra beat
                    state_next = st_last;
                end else begin
                    // Control, error or start inside a frame
                    tlast_next     = 1'b1;
                    tuser_next     = 1'b1;
                    bad_frame_next = 1'b1;
                end
            end
            st_last: begin
                tvalid_next = 1'b1;
                tlast_next  = 1'b1;
                keep_bytes  = {1'b0, code_d1[2:0]} - 4'(fcs_bytes);
                if (!fcs_saved) begin
                    tuser_next     = 1'b1;
                    bad_frame_next = 1'b1;
                    bad_fcs_next   = 1'b1;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state           <= st_idle;
            type_d1         <= blk_idle;
            rx_tvalid       <= 1'b0;
            rx_tlast        <= 1'b0;
            rx_tuser        <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
        end else begin
            state           <= state_next;
            type_d1         <= blk_type;
            rx_tvalid       <= tvalid_next;
            rx_tlast        <= tlast_next;
            rx_tuser        <= tuser_next;
            error_bad_frame <= bad_frame_next;
            error_bad_fcs   <= bad_fcs_next;
        end
    end

    always_ff @(posedge clk) begin
        data_d1  <= blk_data;
        rx_tdata <= data_d1;
        rx_tkeep <= 8'hff >> (4'd8 - keep_bytes); // Low keep_bytes lanes
        if (save_fcs) begin
            fcs_saved <= fcs_match;
        end
    end

endmodule

//--- src/baser_rx_top.sv
// 64-bit 10GBASE-R receive framer. Lane 0 starts only and no PTP timestamps
`timescale 1ns/10ps

module baser_rx_top import baser_rx_pkg::*; (
    input  logic        clk,
    input  logic        reset_crc,
    input  logic [63:0] encoded_rx_data,
    input  logic [1:0]  encoded_rx_hdr,
    input  logic        cfg_rx_enable,
    output logic [63:0] rx_tdata,
    output logic [7:0]  rx_tkeep,
    output logic        rx_tvalid,
    output logic        rx_tlast,
    output logic        rx_tuser,
    output logic        error_bad_frame,
    output logic        error_bad_fcs,
    output logic        rx_bad_block
);

    blk_type_t   blk_type;    // d0 stage
    logic [63:0] blk_data;
    logic        crc_restart;
    logic        fcs_match;

    baser_block_decoder decoder_i (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .encoded_rx_data (encoded_rx_data),
        .encoded_rx_hdr  (encoded_rx_hdr),
        .blk_type        (blk_type),
        .blk_data        (blk_data),
        .rx_bad_block    (rx_bad_block)
    );

    baser_fcs_checker fcs_i (
        .clk         (clk),
        .reset_crc   (reset_crc),
        .crc_restart (crc_restart),
        .blk_type    (blk_type),
        .blk_data    (blk_data),
        .fcs_match   (fcs_match)
    );

    baser_frame_fsm framer_i (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .cfg_rx_enable   (cfg_rx_enable),
        .blk_type        (blk_type),
        .blk_data        (blk_data),
        .fcs_match       (fcs_match),
        .crc_restart     (crc_restart),
        .rx_tdata        (rx_tdata),
        .rx_tkeep        (rx_tkeep),
        .rx_tvalid       (rx_tvalid),
        .rx_tlast        (rx_tlast),
        .rx_tuser        (rx_tuser),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs)
    );

endmodule

//--- tb/baser_rx_tasks.svh
// Tasks share the testbench signals and monitor counters, and each test starts from an idle link

task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_count++;
    if (exp !== act) begin
        err_count++;
        $display("ERR %s: expected 0x%0h, got 0x%0h", name, exp, act);
    end
endtask

task automatic send_block(input logic [1:0] hdr, input logic [63:0] data);
    encoded_rx_hdr  = hdr;
    encoded_rx_data = data;
    @(negedge clk);
endtask

task automatic send_idles(input int n);
    repeat (n) send_block(hdr_ctrl, idle_word);
endtask

task automatic wait_frames(input int n);
    while (frames_seen < n) @(negedge clk);
endtask

task automatic wait_bad_block(input int n);
    while (bad_block_seen < n) @(negedge clk);
endtask

task automatic clear_monitor();
    rx_bytes.delete();
    exp_bytes.delete();
    frames_seen     = 0;
    beats_seen      = 0;
    last_tuser      = 0;
    tuser_early     = 0;
    bad_frame_seen  = 0;
    bad_fcs_seen    = 0;
    strobe_off_last = 0;
    bad_block_seen  = 0;
endtask

// Terminate control codes from the 64b/66b block table
function automatic logic [7:0] term_code(input int k);
    case (k)
        0: return 8'h87;
        1: return 8'h99;
        2: return 8'haa;
        3: return 8'hb4;
        4: return 8'hcc;
        5: return 8'hd2;
        6: return 8'he1;
        default: return 8'hff;
    endcase
endfunction

// Ethernet FCS, bit by bit with LSB first
function automatic logic [31:0] fcs_of(input int len);
    logic [31:0] crc;
    logic        fb;
    crc = 32'hffff_ffff;
    for (int i = 0; i < len; i++) begin
        for (int b = 0; b < 8; b++) begin
            fb  = crc[0] ^ tx_payload[i][b];
            crc = {1'b0, crc[31:1]};
            if (fb) crc = crc ^ 32'hedb8_8320;
        end
    end
    return ~crc;
endfunction

task automatic make_frame(input int len, input bit keep_exp);
    logic [31:0] rnd;
    logic [31:0] fcs;
    tx_payload.delete();
    for (int i = 0; i < len; i++) begin
        rnd = $urandom;
        tx_payload.push_back(rnd[7:0]);
    end
    fcs     = fcs_of(len);
    tx_wire = tx_payload;
    for (int b = 0; b < 4; b++) tx_wire.push_back(fcs[8*b +: 8]);
    if (keep_exp) begin
        foreach (tx_payload[i]) exp_bytes.push_back(tx_payload[i]);
    end
endtask

// Data block number idle_at goes out as an idle block, -1 for none
task automatic send_frame(input int idle_at);
    int          nblk;
    int          k;
    logic [63:0] word;
    nblk = tx_wire.size() / 8;
    k    = tx_wire.size() % 8;
    send_block(hdr_ctrl, {8'hd5, {6{8'h55}}, 8'h78});
    for (int n = 0; n < nblk; n++) begin
        word = '0;
        for (int j = 0; j < 8; j++) word[8*j +: 8] = tx_wire[8*n + j];
        if (n == idle_at) send_block(hdr_ctrl, idle_word);
        else send_block(hdr_data, word);
    end
    word      = '0;
    word[7:0] = term_code(k);
    for (int j = 0; j < k; j++) word[8*(j + 1) +: 8] = tx_wire[8*nblk + j];
    send_block(hdr_ctrl, word);
    send_idles(2);
endtask

task automatic check_results(input int frames, input int tuser, input int bad_frame,
                             input int bad_fcs, input int bad_block);
    compare("frame count", frames, frames_seen);
    if (frames > 0) compare("rx_tuser", tuser, last_tuser);
    compare("rx_tuser before tlast", 0, tuser_early);
    compare("error_bad_frame pulses", bad_frame, bad_frame_seen);
    compare("error_bad_fcs pulses", bad_fcs, bad_fcs_seen);
    compare("error strobe off tlast", 0, strobe_off_last);
    compare("rx_bad_block pulses", bad_block, bad_block_seen);
    compare("byte count", exp_bytes.size(), rx_bytes.size());
    foreach (exp_bytes[i]) begin
        if (i < rx_bytes.size()) compare("rx_tdata byte", exp_bytes[i], rx_bytes[i]);
    end
endtask

task automatic check_reset_state();
    compare("rx_tvalid", 0, rx_tvalid);
    compare("rx_tlast", 0, rx_tlast);
    compare("rx_tuser", 0, rx_tuser);
    compare("error_bad_frame", 0, error_bad_frame);
    compare("error_bad_fcs", 0, error_bad_fcs);
    compare("rx_bad_block", 0, rx_bad_block);
endtask

task automatic test_good_frames();
    int len;
    for (int k = 0; k < 8; k++) begin
        len = 60 + k;   // Payload and FCS leave k bytes for the terminate
        clear_monitor();
        make_frame(len, 1'b1);
        send_frame(-1);
        wait_frames(1);
        send_idles(3);
        check_results(1, 0, 0, 0, 0);
        compare("beat count", (len + 7) / 8, beats_seen);
    end
endtask

task automatic test_bad_fcs();
    int len;
    for (int n = 0; n < 2; n++) begin
        len = (n == 0) ? 50 : 44;   // Terminate 6, then terminate 0
        clear_monitor();
        make_frame(len, 1'b1);
        tx_wire[len + 1] = tx_wire[len + 1] ^ 8'h10;
        send_frame(-1);
        wait_frames(1);
        send_idles(3);
        check_results(1, 1, 1, 1, 0);
    end
endtask

task automatic test_idle_in_frame();
    clear_monitor();
    make_frame(40, 1'b0);
    for (int i = 0; i < 16; i++) exp_bytes.push_back(tx_payload[i]); // Two blocks before the idle
    send_frame(2);
    wait_frames(1);
    send_idles(3);
    check_results(1, 1, 1, 0, 0);
endtask

task automatic test_bad_headers();
    logic [1:0] hdr;
    for (int n = 0; n < 2; n++) begin
        hdr = (n == 0) ? 2'b00 : 2'b11;
        clear_monitor();
        send_block(hdr, 64'h0123_4567_89ab_cdef);
        send_idles(1);
        wait_bad_block(1);
        send_idles(4);
        check_results(0, 0, 0, 0, 1);
        compare("beat count", 0, beats_seen);
    end
endtask

task automatic test_rx_disabled();
    clear_monitor();
    cfg_rx_enable = 1'b0;
    make_frame(30, 1'b0);
    send_frame(-1);
    send_idles(4);
    cfg_rx_enable = 1'b1;
    compare("beat count", 0, beats_seen);
    make_frame(33, 1'b1);
    send_frame(-1);
    wait_frames(1);
    send_idles(3);
    check_results(1, 0, 0, 0, 0);
endtask

task automatic test_ordered_sets();
    clear_monitor();
    make_frame(46, 1'b1);
    send_frame(-1);
    send_block(hdr_ctrl, 64'h0200_0100_0000_002d);
    send_block(hdr_ctrl, 64'h0100_0000_0100_0055);
    send_block(hdr_ctrl, 64'h0000_0001_0000_004b);
    make_frame(52, 1'b1);
    send_frame(-1);
    wait_frames(2);
    send_idles(3);
    check_results(2, 0, 0, 0, 0);
endtask

//--- tb/baser_rx_tb.sv
// Directed tests for lane 0 starts only. Inputs change on the falling edge, outputs are read there too
`timescale 1ns/10ps

module baser_rx_tb;

    localparam int          max_cycles = 4000;       // Well above the whole test sequence
    localparam logic [1:0]  hdr_data   = 2'b10;
    localparam logic [1:0]  hdr_ctrl   = 2'b01;
    localparam logic [63:0] idle_word  = 64'h1e;     // Control block of idles

    logic        clk;
    logic        reset_crc;
    logic [63:0] encoded_rx_data;
    logic [1:0]  encoded_rx_hdr;
    logic        cfg_rx_enable;
    logic [63:0] rx_tdata;
    logic [7:0]  rx_tkeep;
    logic        rx_tvalid;
    logic        rx_tlast;
    logic        rx_tuser;
    logic        error_bad_frame;
    logic        error_bad_fcs;
    logic        rx_bad_block;

    logic [7:0]  tx_payload[$];
    logic [7:0]  tx_wire[$];    // Payload followed by its FCS
    logic [7:0]  exp_bytes[$];
    logic [7:0]  rx_bytes[$];
    logic [31:0] seed_ret;

    // Monitor counters
    int frames_seen     = 0;
    int beats_seen      = 0;
    int last_tuser      = 0;    // Last beats that carried tuser
    int tuser_early     = 0;
    int bad_frame_seen  = 0;
    int bad_fcs_seen    = 0;
    int strobe_off_last = 0;
    int bad_block_seen  = 0;

    int err_count   = 0;
    int check_count = 0;
    int cycle_count = 0;

    baser_rx_top dut_i (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .encoded_rx_data (encoded_rx_data),
        .encoded_rx_hdr  (encoded_rx_hdr),
        .cfg_rx_enable   (cfg_rx_enable),
        .rx_tdata        (rx_tdata),
        .rx_tkeep        (rx_tkeep),
        .rx_tvalid       (rx_tvalid),
        .rx_tlast        (rx_tlast),
        .rx_tuser        (rx_tuser),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs),
        .rx_bad_block    (rx_bad_block)
    );

    `include "baser_rx_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // Collects kept bytes of every beat
    always @(negedge clk) begin
        if (rx_tvalid) begin
            for (int i = 0; i < 8; i++) begin
                if (rx_tkeep[i]) rx_bytes.push_back(rx_tdata[8*i +: 8]);
            end
            beats_seen++;
            if (rx_tlast) begin
                frames_seen++;
                last_tuser += rx_tuser;
            end else if (rx_tuser) begin
                tuser_early++;
            end
        end
        if (error_bad_frame) bad_frame_seen++;
        if (error_bad_fcs) bad_fcs_seen++;
        if ((error_bad_frame || error_bad_fcs) && !(rx_tvalid && rx_tlast)) begin
            strobe_off_last++;  // Strobes belong to the tlast beat
        end
        if (rx_bad_block) bad_block_seen++;
    end

    initial begin
        seed_ret        = $urandom(5476);
        reset_crc       = 1'b1;
        encoded_rx_hdr  = hdr_ctrl;
        encoded_rx_data = idle_word;
        cfg_rx_enable   = 1'b1;
        repeat (2) @(negedge clk);
        reset_crc = 1'b0;
        check_reset_state();
        test_good_frames();
        test_bad_fcs();
        test_idle_in_frame();
        test_bad_headers();
        test_rx_disabled();
        test_ordered_sets();
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+tb
src/baser_rx_pkg.sv
src/baser_block_decoder.sv
src/baser_fcs_checker.sv
src/baser_frame_fsm.sv
src/baser_rx_top.sv
tb/baser_rx_tb.sv
